// ==== logic/isaPkg.sv ====
package isaPkg;

  // base widths
  localparam int wordWidth = 16;
  localparam int regAddrWidth = 3;
  localparam int pcWidth = 8;
  localparam int dAddrWidth = 8;
  localparam int opWidth = 5;

  // storage sizes
  localparam int imemDepth = 256;
  localparam int dmemDepth = 256;
  localparam int numRegs = 8;

  // instruction field positions
  localparam int opMsb = 15;
  localparam int opLsb = 11;
  localparam int rdMsb = 10;
  localparam int rdLsb = 8;
  localparam int rsMsb = 7;
  localparam int rsLsb = 5;
  localparam int immMsb = 7;
  localparam int immLsb = 0;
  // shift amount sits in the low bits of the immediate
  localparam int shMsb = 3;
  localparam int shLsb = 0;

  typedef logic [wordWidth-1:0] word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;
  typedef logic [pcWidth-1:0] pc_t;
  typedef logic [dAddrWidth-1:0] dAddr_t;
  typedef logic [wordWidth-1:0] instr_t;

  // two-operand ops use rd as destination and first source
  // NOT, INC, SHL, SHR work on rd alone
  // LDD loads rd from mem[rs], STD stores rd to mem[rs]
  typedef enum logic [opWidth-1:0] {
    opNop = 5'd0,
    opMov = 5'd1,
    opAdd = 5'd2,
    opSub = 5'd3,
    opAnd = 5'd4,
    opOr  = 5'd5,
    opNot = 5'd6,
    opInc = 5'd7,
    opShl = 5'd8,
    opShr = 5'd9,
    opLdm = 5'd10,
    opLdd = 5'd11,
    opStd = 5'd12,
    opIn  = 5'd13,
    opOut = 5'd14,
    opHlt = 5'd15
  } opcode_e;

endpackage

// ==== logic/pipePkg.sv ====
package pipePkg;

  // fetch to decode
  typedef struct packed {
    logic valid;
    isaPkg::pc_t pc;
    isaPkg::instr_t instr;
  } ifId_t;

  // decode to execute, control bits already gated by valid
  typedef struct packed {
    logic valid;
    isaPkg::opcode_e op;
    isaPkg::regAddr_t rd;
    isaPkg::regAddr_t rs;
    isaPkg::word_t rdVal;
    isaPkg::word_t rsVal;
    logic [isaPkg::immMsb-isaPkg::immLsb:0] imm;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic isIn;
    logic isOut;
    logic isHalt;
  } idEx_t;

  // execute to memory
  typedef struct packed {
    logic valid;
    isaPkg::regAddr_t rd;
    isaPkg::word_t result;
    isaPkg::word_t storeData;
    isaPkg::dAddr_t addr;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic isOut;
    logic isHalt;
  } exMem_t;

  // memory to writeback
  typedef struct packed {
    logic valid;
    isaPkg::regAddr_t rd;
    isaPkg::word_t data;
    logic regWrite;
    logic isOut;
    logic isHalt;
  } memWb_t;

  // register write bundle, also used as a forwarding source
  typedef struct packed {
    logic we;
    isaPkg::regAddr_t rd;
    isaPkg::word_t data;
  } fwd_t;

endpackage

// ==== logic/fetchStage.sv ====
`timescale 1ns/100ps

module fetchStage (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            progWe,
  input  isaPkg::pc_t     progAddr,
  input  isaPkg::instr_t  progData,
  input  logic            pipeHold,
  input  logic            loadUse,
  input  logic            haltSeen,
  output logic            halted,
  output pipePkg::ifId_t  ifId
);

  isaPkg::instr_t imem [isaPkg::imemDepth];
  isaPkg::pc_t pc;
  isaPkg::instr_t fetchWord;
  logic running;
  // set once a HLT has been fetched
  logic fetchStop;
  logic advance;

  assign fetchWord = imem[pc];
  // decode stalls on load-use, whole pipe on port waits
  assign advance = running & ~pipeHold & ~loadUse;

  // program load only while idle
  always_ff @(posedge clk)
  begin
    if (progWe && !running)
    begin
      imem[progAddr] <= progData;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc <= '0;
      running <= 1'b0;
      halted <= 1'b0;
      fetchStop <= 1'b0;
      ifId <= '0;
    end
    else if (start && !running)
    begin
      // fresh run from address zero
      pc <= '0;
      running <= 1'b1;
      halted <= 1'b0;
      fetchStop <= 1'b0;
      ifId <= '0;
    end
    else if (haltSeen && running)
    begin
      running <= 1'b0;
      halted <= 1'b1;
      ifId <= '0;
    end
    else if (advance)
    begin
      if (fetchStop)
      begin
        // drain with bubbles until HLT retires
        ifId <= '0;
      end
      else
      begin
        ifId <= '{valid: 1'b1, pc: pc, instr: fetchWord};
        pc <= pc + isaPkg::pc_t'(1);
        fetchStop <= (fetchWord[isaPkg::opMsb:isaPkg::opLsb] == isaPkg::opHlt);
      end
    end
  end

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
  input  logic            clk,
  input  logic            rst,
  input  pipePkg::ifId_t  ifId,
  input  pipePkg::fwd_t   wbWrite,
  input  logic            pipeHold,
  output logic            loadUse,
  output pipePkg::idEx_t  idEx
);

  isaPkg::word_t regs [isaPkg::numRegs];
  isaPkg::opcode_e op;
  isaPkg::regAddr_t rd;
  isaPkg::regAddr_t rs;
  logic [isaPkg::immMsb-isaPkg::immLsb:0] imm;
  isaPkg::word_t rdVal;
  isaPkg::word_t rsVal;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic isIn;
  logic isOut;
  logic isHalt;
  // which register fields are real sources
  logic usesRd;
  logic usesRs;
  pipePkg::idEx_t nextIdEx;

  // field split
  assign op = isaPkg::opcode_e'(ifId.instr[isaPkg::opMsb:isaPkg::opLsb]);
  assign rd = ifId.instr[isaPkg::rdMsb:isaPkg::rdLsb];
  assign rs = ifId.instr[isaPkg::rsMsb:isaPkg::rsLsb];
  assign imm = ifId.instr[isaPkg::immMsb:isaPkg::immLsb];

  always_comb
  begin
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    isIn = 1'b0;
    isOut = 1'b0;
    isHalt = 1'b0;
    usesRd = 1'b0;
    usesRs = 1'b0;
    case (op)
      isaPkg::opMov:
      begin
        regWrite = 1'b1;
        usesRs = 1'b1;
      end
      isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr:
      begin
        regWrite = 1'b1;
        usesRd = 1'b1;
        usesRs = 1'b1;
      end
      isaPkg::opNot, isaPkg::opInc, isaPkg::opShl, isaPkg::opShr:
      begin
        regWrite = 1'b1;
        usesRd = 1'b1;
      end
      isaPkg::opLdm: regWrite = 1'b1;
      isaPkg::opLdd:
      begin
        regWrite = 1'b1;
        memRead = 1'b1;
        usesRs = 1'b1;
      end
      isaPkg::opStd:
      begin
        // rd is store data, rs the address
        memWrite = 1'b1;
        usesRd = 1'b1;
        usesRs = 1'b1;
      end
      isaPkg::opIn:
      begin
        regWrite = 1'b1;
        isIn = 1'b1;
      end
      isaPkg::opOut:
      begin
        isOut = 1'b1;
        usesRd = 1'b1;
      end
      isaPkg::opHlt: isHalt = 1'b1;
      default: ;
    endcase
  end

  // register file, writeback lands at the clock edge
  always_ff @(posedge clk)
  begin
    if (wbWrite.we)
    begin
      regs[wbWrite.rd] <= wbWrite.data;
    end
  end

  // same-cycle write seen by the read
  assign rdVal = (wbWrite.we && wbWrite.rd == rd) ? wbWrite.data : regs[rd];
  assign rsVal = (wbWrite.we && wbWrite.rd == rs) ? wbWrite.data : regs[rs];

  // LDD in execute has no data yet for a dependent reader
  assign loadUse = idEx.valid & idEx.memRead & ifId.valid &
                   ((usesRd & (rd == idEx.rd)) | (usesRs & (rs == idEx.rd)));

  always_comb
  begin
    nextIdEx.valid = ifId.valid;
    nextIdEx.op = op;
    nextIdEx.rd = rd;
    nextIdEx.rs = rs;
    nextIdEx.rdVal = rdVal;
    nextIdEx.rsVal = rsVal;
    nextIdEx.imm = imm;
    nextIdEx.regWrite = regWrite & ifId.valid;
    nextIdEx.memRead = memRead & ifId.valid;
    nextIdEx.memWrite = memWrite & ifId.valid;
    nextIdEx.isIn = isIn & ifId.valid;
    nextIdEx.isOut = isOut & ifId.valid;
    nextIdEx.isHalt = isHalt & ifId.valid;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      idEx <= '0;
    end
    else if (!pipeHold)
    begin
      // bubble while the dependent instruction waits in decode
      idEx <= loadUse ? '0 : nextIdEx;
    end
  end

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
  input  logic             clk,
  input  logic             rst,
  input  pipePkg::idEx_t   idEx,
  input  pipePkg::fwd_t    exFwd,
  input  pipePkg::fwd_t    wbFwd,
  input  logic             pipeHold,
  input  isaPkg::word_t    inData,
  input  logic             inValid,
  output logic             inReady,
  output logic             exHold,
  output pipePkg::exMem_t  exMem
);

  // operand A comes from rd, operand B from rs
  isaPkg::word_t opA;
  isaPkg::word_t opB;
  isaPkg::word_t aluOut;
  logic [isaPkg::shMsb-isaPkg::shLsb:0] shamt;
  pipePkg::exMem_t nextExMem;

  // youngest producer wins
  function automatic isaPkg::word_t pickOperand(
    input isaPkg::regAddr_t r,
    input isaPkg::word_t regVal,
    input pipePkg::fwd_t nearFwd,
    input pipePkg::fwd_t farFwd
  );
    if (nearFwd.we && nearFwd.rd == r)
    begin
      return nearFwd.data;
    end
    else if (farFwd.we && farFwd.rd == r)
    begin
      return farFwd.data;
    end
    return regVal;
  endfunction

  assign opA = pickOperand(idEx.rd, idEx.rdVal, exFwd, wbFwd);
  assign opB = pickOperand(idEx.rs, idEx.rsVal, exFwd, wbFwd);
  assign shamt = idEx.imm[isaPkg::shMsb:isaPkg::shLsb];

  always_comb
  begin
    case (idEx.op)
      isaPkg::opMov: aluOut = opB;
      isaPkg::opAdd: aluOut = opA + opB;
      isaPkg::opSub: aluOut = opA - opB;
      isaPkg::opAnd: aluOut = opA & opB;
      isaPkg::opOr:  aluOut = opA | opB;
      isaPkg::opNot: aluOut = ~opA;
      isaPkg::opInc: aluOut = opA + isaPkg::word_t'(1);
      isaPkg::opShl: aluOut = opA << shamt;
      isaPkg::opShr: aluOut = opA >> shamt;
      // zero-extended immediate
      isaPkg::opLdm: aluOut = isaPkg::word_t'(idEx.imm);
      isaPkg::opIn:  aluOut = inData;
      // OUT carries the forwarded rd value down to the port
      isaPkg::opOut: aluOut = opA;
      default:       aluOut = '0;
    endcase
  end

  // IN stalls the whole pipe until the port has data
  assign exHold = idEx.valid & idEx.isIn & ~inValid;
  assign inReady = idEx.valid & idEx.isIn & ~pipeHold;

  always_comb
  begin
    nextExMem.valid = idEx.valid;
    nextExMem.rd = idEx.rd;
    nextExMem.result = aluOut;
    nextExMem.storeData = opA;
    // low byte of rs addresses data memory
    nextExMem.addr = isaPkg::dAddr_t'(opB);
    nextExMem.regWrite = idEx.regWrite;
    nextExMem.memRead = idEx.memRead;
    nextExMem.memWrite = idEx.memWrite;
    nextExMem.isOut = idEx.isOut;
    nextExMem.isHalt = idEx.isHalt;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      exMem <= '0;
    end
    else if (!pipeHold)
    begin
      exMem <= nextExMem;
    end
  end

endmodule

// ==== logic/memWbStage.sv ====
`timescale 1ns/100ps

module memWbStage (
  input  logic             clk,
  input  logic             rst,
  input  pipePkg::exMem_t  exMem,
  input  logic             exHold,
  input  logic             outReady,
  output logic             pipeHold,
  output pipePkg::fwd_t    exFwd,
  output pipePkg::fwd_t    wbWrite,
  output isaPkg::word_t    outData,
  output logic             outValid,
  output logic             haltSeen
);

  isaPkg::word_t dmem [isaPkg::dmemDepth];
  isaPkg::word_t loadData;
  pipePkg::memWb_t memWb;
  pipePkg::memWb_t nextMemWb;
  // OUT stuck behind a busy consumer
  logic wbBlock;

  assign wbBlock = memWb.valid & memWb.isOut & ~outReady;
  assign pipeHold = wbBlock | exHold;

  // store only when the STD moves on, so a held STD writes once
  always_ff @(posedge clk)
  begin
    if (exMem.valid && exMem.memWrite && !pipeHold)
    begin
      dmem[exMem.addr] <= exMem.storeData;
    end
  end

  // asynchronous read feeds the memWb register
  assign loadData = dmem[exMem.addr];

  always_comb
  begin
    nextMemWb.valid = exMem.valid;
    nextMemWb.rd = exMem.rd;
    nextMemWb.data = exMem.memRead ? loadData : exMem.result;
    nextMemWb.regWrite = exMem.regWrite;
    nextMemWb.isOut = exMem.isOut;
    nextMemWb.isHalt = exMem.isHalt;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      memWb <= '0;
    end
    else if (wbBlock)
    begin
      memWb <= memWb;
    end
    else if (exHold)
    begin
      // current entry retires, exMem is frozen behind it
      memWb <= '0;
    end
    else
    begin
      memWb <= nextMemWb;
    end
  end

  // load results are not ready in this stage
  assign exFwd = '{we: exMem.valid & exMem.regWrite & ~exMem.memRead,
                   rd: exMem.rd,
                   data: exMem.result};

  assign wbWrite = '{we: memWb.valid & memWb.regWrite, rd: memWb.rd, data: memWb.data};

  // output port stays put while blocked
  assign outData = memWb.data;
  assign outValid = memWb.valid & memWb.isOut;
  assign haltSeen = memWb.valid & memWb.isHalt;

endmodule

// ==== logic/pipe16Top.sv ====
`timescale 1ns/100ps

module pipe16Top (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            progWe,
  input  isaPkg::pc_t     progAddr,
  input  isaPkg::instr_t  progData,
  input  isaPkg::word_t   inData,
  input  logic            inValid,
  output logic            inReady,
  output isaPkg::word_t   outData,
  output logic            outValid,
  input  logic            outReady,
  output logic            halted
);

  // stage registers
  pipePkg::ifId_t ifId;
  pipePkg::idEx_t idEx;
  pipePkg::exMem_t exMem;
  // writeback and forwarding bundles
  pipePkg::fwd_t exFwd;
  pipePkg::fwd_t wbWrite;
  // stall and halt controls
  logic pipeHold;
  logic loadUse;
  logic exHold;
  logic haltSeen;

  fetchStage uFetch (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .pipeHold (pipeHold),
    .loadUse  (loadUse),
    .haltSeen (haltSeen),
    .halted   (halted),
    .ifId     (ifId)
  );

  decodeStage uDecode (
    .clk      (clk),
    .rst      (rst),
    .ifId     (ifId),
    .wbWrite  (wbWrite),
    .pipeHold (pipeHold),
    .loadUse  (loadUse),
    .idEx     (idEx)
  );

  // writeback bundle doubles as the far forwarding source
  executeStage uExecute (
    .clk      (clk),
    .rst      (rst),
    .idEx     (idEx),
    .exFwd    (exFwd),
    .wbFwd    (wbWrite),
    .pipeHold (pipeHold),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .exHold   (exHold),
    .exMem    (exMem)
  );

  memWbStage uMemWb (
    .clk      (clk),
    .rst      (rst),
    .exMem    (exMem),
    .exHold   (exHold),
    .outReady (outReady),
    .pipeHold (pipeHold),
    .exFwd    (exFwd),
    .wbWrite  (wbWrite),
    .outData  (outData),
    .outValid (outValid),
    .haltSeen (haltSeen)
  );

endmodule

// ==== bench/refModel.svh ====
`ifndef REFMODEL_SVH
`define REFMODEL_SVH

// instruction-level ISA model, no pipeline timing at all
// walks the program until HLT and collects the OUT stream
function automatic void predictOutputs(
  ref isaPkg::instr_t prog [$],
  ref isaPkg::word_t inputs [$],
  ref isaPkg::word_t outs [$]
);
  isaPkg::word_t regs [isaPkg::numRegs];
  isaPkg::word_t mem [isaPkg::dmemDepth];
  isaPkg::instr_t ins;
  isaPkg::opcode_e op;
  isaPkg::regAddr_t rd;
  isaPkg::regAddr_t rs;
  logic [7:0] imm;
  int pc;
  int inIdx;
  logic done;
  outs.delete();
  for (int r = 0; r < isaPkg::numRegs; r++)
  begin
    regs[r] = '0;
  end
  pc = 0;
  inIdx = 0;
  done = 1'b0;
  while (!done && pc < prog.size())
  begin
    ins = prog[pc];
    pc++;
    op = isaPkg::opcode_e'(ins[isaPkg::opMsb:isaPkg::opLsb]);
    rd = ins[isaPkg::rdMsb:isaPkg::rdLsb];
    rs = ins[isaPkg::rsMsb:isaPkg::rsLsb];
    imm = ins[isaPkg::immMsb:isaPkg::immLsb];
    case (op)
      isaPkg::opMov: regs[rd] = regs[rs];
      isaPkg::opAdd: regs[rd] = regs[rd] + regs[rs];
      isaPkg::opSub: regs[rd] = regs[rd] - regs[rs];
      isaPkg::opAnd: regs[rd] = regs[rd] & regs[rs];
      isaPkg::opOr:  regs[rd] = regs[rd] | regs[rs];
      isaPkg::opNot: regs[rd] = ~regs[rd];
      isaPkg::opInc: regs[rd] = regs[rd] + 16'd1;
      // shift count is the low nibble
      isaPkg::opShl: regs[rd] = regs[rd] << imm[3:0];
      isaPkg::opShr: regs[rd] = regs[rd] >> imm[3:0];
      isaPkg::opLdm: regs[rd] = {8'h00, imm};
      // address is the low byte of rs
      isaPkg::opLdd: regs[rd] = mem[regs[rs][7:0]];
      isaPkg::opStd: mem[regs[rs][7:0]] = regs[rd];
      isaPkg::opIn:
      begin
        regs[rd] = inputs[inIdx];
        inIdx++;
      end
      isaPkg::opOut: outs.push_back(regs[rd]);
      isaPkg::opHlt: done = 1'b1;
      default: ;
    endcase
  end
endfunction

`endif

// ==== bench/pipe16Tb.sv ====
`timescale 1ns/100ps

module pipe16Tb;

  // cycles allowed from start until halted
  localparam int runLimit = 4000;
  // a few data words the programs share
  localparam isaPkg::dAddr_t scratch [4] = '{8'h13, 8'h3c, 8'h65, 8'h8e};

  logic clk;
  logic rst;
  logic start;
  logic progWe;
  isaPkg::pc_t progAddr;
  isaPkg::instr_t progData;
  isaPkg::word_t inData;
  logic inValid;
  logic inReady;
  isaPkg::word_t outData;
  logic outValid;
  logic outReady;
  logic halted;

  // program, queued input values, predicted outputs
  isaPkg::instr_t progQ [$];
  isaPkg::word_t inQ [$];
  isaPkg::word_t expQ [$];
  int outIdx;

  `include "refModel.svh"

  pipe16Top u_dut (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady),
    .halted   (halted)
  );

  always #10 clk = ~clk;

  task automatic abortRun();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input isaPkg::word_t got,
                           input isaPkg::word_t exp);
    if (got !== exp)
    begin
      $display("error: %s is %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error: %s is %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  function automatic isaPkg::instr_t encode(input isaPkg::opcode_e op,
                                            input isaPkg::regAddr_t rd,
                                            input logic [7:0] low);
    return {op, rd, low};
  endfunction

  // register-register form puts rs in the top bits of the low byte
  function automatic isaPkg::instr_t encodeRR(input isaPkg::opcode_e op,
                                              input isaPkg::regAddr_t rd,
                                              input isaPkg::regAddr_t rs);
    return encode(op, rd, {rs, 5'b00000});
  endfunction

  // mostly r0..r3 for dense reuse and now and then up to r6
  function automatic isaPkg::regAddr_t pickReg();
    if ($urandom_range(0, 4) == 0)
      return isaPkg::regAddr_t'($urandom_range(0, 6));
    return isaPkg::regAddr_t'($urandom_range(0, 3));
  endfunction

  task automatic buildProgram(input int bodyLen);
    int kind;
    int k;
    int i;
    isaPkg::regAddr_t a;
    isaPkg::regAddr_t b;
    isaPkg::opcode_e op;
    progQ.delete();
    inQ.delete();
    // every register starts from a known value
    for (int r = 0; r < isaPkg::numRegs; r++)
    begin
      progQ.push_back(encode(isaPkg::opLdm, isaPkg::regAddr_t'(r), 8'($urandom)));
    end
    // scratch words defined before any load with r7 as address
    for (int s = 0; s < 4; s++)
    begin
      progQ.push_back(encode(isaPkg::opLdm, 3'd7, scratch[s]));
      progQ.push_back(encodeRR(isaPkg::opStd, pickReg(), 3'd7));
    end
    i = 0;
    // cap keeps the whole program inside imem
    while (i < bodyLen && progQ.size() < 240)
    begin
      kind = $urandom_range(0, 15);
      a = pickReg();
      b = pickReg();
      if (kind < 7)
      begin
        op = isaPkg::opcode_e'(5'($urandom_range(1, 9)));
        if (op == isaPkg::opShl || op == isaPkg::opShr)
          progQ.push_back(encode(op, a, {4'h0, 4'($urandom)}));
        else
          progQ.push_back(encodeRR(op, a, b));
      end
      else if (kind == 7)
      begin
        progQ.push_back(encode(isaPkg::opLdm, a, 8'($urandom)));
      end
      else if (kind < 11)
      begin
        // store then load back at once with a dependent use right after
        k = $urandom_range(0, 3);
        progQ.push_back(encode(isaPkg::opLdm, 3'd7, scratch[k]));
        if (kind != 10)
          progQ.push_back(encodeRR(isaPkg::opStd, a, 3'd7));
        progQ.push_back(encodeRR(isaPkg::opLdd, b, 3'd7));
        progQ.push_back(encodeRR(isaPkg::opAdd, b, a));
        progQ.push_back(encode(isaPkg::opOut, b, 8'h00));
      end
      else if (kind < 13)
      begin
        progQ.push_back(encode(isaPkg::opIn, a, 8'h00));
        inQ.push_back(isaPkg::word_t'($urandom));
      end
      else
      begin
        progQ.push_back(encode(isaPkg::opOut, a, 8'h00));
      end
      i++;
    end
    progQ.push_back(encode(isaPkg::opHlt, 3'd0, 8'h00));
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progQ.size(); i++)
    begin
      @(posedge clk);
      #1;
      progWe = 1'b1;
      progAddr = isaPkg::pc_t'(i);
      progData = progQ[i];
    end
    @(posedge clk);
    #1;
    progWe = 1'b0;
  endtask

  task automatic startCore();
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic takeOutput(input isaPkg::word_t value);
    if (outIdx >= expQ.size())
    begin
      $display("core produced more outputs than predicted, extra value %h", value);
      abortRun();
    end
    else
    begin
      checkWord("outData", value, expQ[outIdx]);
      outIdx++;
    end
  endtask

  // port handling until halted with sampling at the falling edge
  task automatic serviceRun();
    int cycles;
    int inIdx;
    logic inFire;
    logic outFire;
    logic wasBlocked;
    isaPkg::word_t heldData;
    cycles = 0;
    inIdx = 0;
    outIdx = 0;
    wasBlocked = 1'b0;
    heldData = '0;
    while (!halted)
    begin
      @(negedge clk);
      // blocked output must not move or vanish
      if (wasBlocked)
      begin
        checkFlag("outValid", outValid, 1'b1);
        checkWord("outData", outData, heldData);
      end
      inFire = inValid & inReady;
      outFire = outValid & outReady;
      if (outFire)
        takeOutput(outData);
      wasBlocked = outValid & ~outReady;
      heldData = outData;
      if (inFire)
        inIdx++;
      @(posedge clk);
      #1;
      // valid stays up until taken and gaps fall only between values
      if (inFire || !inValid)
      begin
        if (inIdx < inQ.size() && $urandom_range(0, 2) != 0)
        begin
          inValid = 1'b1;
          inData = inQ[inIdx];
        end
        else
        begin
          inValid = 1'b0;
          inData = isaPkg::word_t'($urandom);
        end
      end
      outReady = ($urandom_range(0, 3) != 0);
      cycles++;
      if (cycles > runLimit)
      begin
        $display("timeout, core did not halt within %0d cycles", runLimit);
        abortRun();
      end
    end
  endtask

  // after halt the ports stay quiet
  task automatic confirmHaltQuiet();
    // an offered input must not be taken once halted
    inValid = 1'b1;
    inData = isaPkg::word_t'($urandom);
    outReady = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      checkFlag("outValid", outValid, 1'b0);
      checkFlag("inReady", inReady, 1'b0);
      checkFlag("halted", halted, 1'b1);
    end
    @(posedge clk);
    #1;
    inValid = 1'b0;
    if (outIdx != expQ.size())
    begin
      $display("core gave %0d outputs, model predicts %0d", outIdx, expQ.size());
      abortRun();
    end
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    inData = '0;
    inValid = 1'b0;
    outReady = 1'b0;
    outIdx = 0;
    void'($urandom(32'h4b41_ccec));
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // input offered so a stray inReady would show
    inValid = 1'b1;
    @(negedge clk);
    // idle core after reset
    checkFlag("outValid", outValid, 1'b0);
    checkFlag("inReady", inReady, 1'b0);
    checkFlag("halted", halted, 1'b0);
    @(posedge clk);
    #1;
    inValid = 1'b0;
    // second program also covers restart after halt
    for (int run = 0; run < 2; run++)
    begin
      buildProgram(60);
      predictOutputs(progQ, inQ, expQ);
      loadProgram();
      startCore();
      serviceRun();
      confirmHaltQuiet();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== pipe16.f ====
+incdir+bench
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/pipe16Top.sv
bench/pipe16Tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -j 0 \
  --top-module pipe16Tb -f pipe16.f

./obj_dir/Vpipe16Tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
